/* Makefile */
# Verilator flow for the single-cycle MIPS core
# Override on the command line, for example: make sim SEED_RUNS=5 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mips_uniciclo
SEED_RUNS ?= 20
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --timing -f $(FILELIST) --top-module $(TOP) -Gnum_programs=$(SEED_RUNS)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides pass or fail, whatever the simulator exit status was
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	localparam int data_width      = 32; // Register and data word width
	localparam int reg_addr_width  = 5;  // Register index width
	localparam int imem_addr_width = 7;  // Instruction memory word address, 128 words
	localparam int dmem_addr_width = 7;  // Data memory word address, 128 words

	// Primary opcode field, instruction bits 31:26
	typedef enum logic [5:0] {
		r_type = 6'h00, // Register format, operation in funct
		j      = 6'h02, // Jump
		jal    = 6'h03, // Jump and link into r31
		beq    = 6'h04, // Branch if equal
		bne    = 6'h05, // Branch if not equal
		addi   = 6'h08, // Add immediate
		slti   = 6'h0a, // Set less than immediate, signed
		andi   = 6'h0c, // And with zero extended immediate
		ori    = 6'h0d, // Or with zero extended immediate
		lui    = 6'h0f, // Load upper immediate
		lw     = 6'h23, // Load word
		sw     = 6'h2b  // Store word
	} opcode_t;

	// Function field of register format, bits 5:0
	typedef enum logic [5:0] {
		f_jr  = 6'h08, // Jump to register
		f_add = 6'h20,
		f_sub = 6'h22,
		f_and = 6'h24,
		f_or  = 6'h25,
		f_slt = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4, // Signed compare, result is 0 or 1
		alu_lui = 3'd5  // Immediate moved to upper half
	} alu_op_t;

	typedef enum logic [1:0] {
		pc_seq    = 2'd0, // PC plus 4
		pc_branch = 2'd1, // Conditional relative branch
		pc_jump   = 2'd2, // Absolute jump inside the 256 MB region
		pc_reg    = 2'd3  // Target from rs
	} pc_src_t;

	typedef enum logic [1:0] {
		dst_rt = 2'd0, // Immediate format destination
		dst_rd = 2'd1, // Register format destination
		dst_ra = 2'd2  // Link register r31
	} reg_dst_t;

	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_mem  = 2'd1,
		wb_link = 2'd2 // Return address for jal
	} wb_sel_t;

endpackage

`default_nettype wire

/* mips_uniciclo/mips_uniciclo.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_uniciclo (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 imem_load, // Program load strobe, used in reset
	input  logic [mips_pkg::imem_addr_width-1:0] imem_addr,
	input  logic [mips_pkg::data_width-1:0]      imem_data,
	output logic [mips_pkg::data_width-1:0]      pc,
	output logic [mips_pkg::data_width-1:0]      alu_result,
	output logic                                 mem_write,
	output logic [mips_pkg::dmem_addr_width-1:0] mem_addr,  // Data memory word address
	output logic [mips_pkg::data_width-1:0]      mem_wdata
);
	import mips_pkg::*;

	logic [data_width-1:0]      instruction;
	logic [imem_addr_width-1:0] inst_address;
	logic                       inst_write;
	pc_src_t                    pc_src;
	logic                       branch_ne;
	reg_dst_t                   reg_dst;
	wb_sel_t                    wb_sel;
	logic                       reg_write;
	logic                       ctrl_mem_write; // Store request before the reset hold
	logic                       alu_src;
	alu_op_t                    alu_op;
	logic [data_width-1:0]      imm_ext;
	logic [data_width-1:0]      read_data1;
	logic [data_width-1:0]      read_data2;
	logic                       equal;
	logic [data_width-1:0]      return_address;
	logic [data_width-1:0]      mem_data;

	assign inst_address = reset ? imem_addr : pc[imem_addr_width+1:2]; // Loader owns the port in reset
	assign inst_write   = imem_load & reset;
	assign mem_write    = ctrl_mem_write & ~reset; // No stores while the loader runs
	assign mem_addr     = alu_result[dmem_addr_width+1:2];
	assign mem_wdata    = read_data2;

	program_counter p_counter (
		.clk            (clk),
		.reset          (reset),
		.pc_src         (pc_src),
		.branch_ne      (branch_ne),
		.equal          (equal),
		.imm_ext        (imm_ext),
		.reg_target     (read_data1),          // jr target
		.jump_index     (instruction[25:0]),
		.pc             (pc),
		.return_address (return_address)
	);

	register_bank reg_bank (
		.clk            (clk),
		.reset          (reset),
		.rs             (instruction[25:21]),
		.rt             (instruction[20:16]),
		.rd             (instruction[15:11]),
		.reg_dst        (reg_dst),
		.reg_write      (reg_write),
		.wb_sel         (wb_sel),
		.alu_result     (alu_result),
		.mem_data       (mem_data),
		.return_address (return_address),
		.read_data1     (read_data1),
		.read_data2     (read_data2)
	);

	control_unit ctrl (
		.instruction (instruction),
		.pc_src      (pc_src),
		.branch_ne   (branch_ne),
		.reg_dst     (reg_dst),
		.wb_sel      (wb_sel),
		.reg_write   (reg_write),
		.mem_write   (ctrl_mem_write),
		.alu_src     (alu_src),
		.alu_op      (alu_op),
		.imm_ext     (imm_ext)
	);

	alu main_alu (
		.operand_a  (read_data1),
		.read_data2 (read_data2),
		.imm_ext    (imm_ext),
		.alu_src    (alu_src),
		.alu_op     (alu_op),
		.result     (alu_result),
		.equal      (equal)
	);

	word_memory #(.addr_width(imem_addr_width)) inst_memory (
		.clk        (clk),
		.write      (inst_write),
		.address    (inst_address),
		.write_data (imem_data),
		.read_data  (instruction)
	);

	word_memory #(.addr_width(dmem_addr_width)) data_memory (
		.clk        (clk),
		.write      (mem_write),
		.address    (mem_addr),
		.write_data (mem_wdata),
		.read_data  (mem_data)
	);

endmodule

`default_nettype wire

/* testbench/mips_ref_model.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] rand_below(input logic [31:0] n);
	rng_state = xorshift32(rng_state); // Advance the generator state
	return rng_state % n;
endfunction

function automatic logic [5:0] alu_funct(input logic [31:0] n);
	case (n % 5)
		0: return f_add;
		1: return f_sub;
		2: return f_and;
		3: return f_or;
		default: return f_slt;
	endcase
endfunction

function automatic logic [5:0] imm_opcode(input logic [31:0] n);
	case (n % 5)
		0: return addi;
		1: return slti;
		2: return andi; // Zero extended
		3: return ori;  // Zero extended
		default: return lui;
	endcase
endfunction

// Random program of prog_len words, then a jump to itself
function automatic void gen_program();
	logic [31:0] kind;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	int          t;
	int          i;
	for (int k = 0; k < imem_words; k++) begin
		prog[k]      = 32'd0; // Padding decodes as a no-op
		is_target[k] = 1'b0;
	end
	prog[prog_len] = {j, 26'(prog_len)}; // Final spin
	i = 0;
	while (i < prog_len) begin
		kind = rand_below(16);
		a    = rand_below(8);            // Registers r0 to r7
		b    = rand_below(8);
		c    = rand_below(32'hffff_ffff); // Immediates and spare fields
		if (kind < 6) begin
			prog[i] = {6'h00, a[4:0], b[4:0], 2'b00, c[18:16], 5'd0, alu_funct(c >> 20)};
		end else if (kind < 10) begin
			prog[i] = {imm_opcode(c >> 16), a[4:0], b[4:0], c[15:0]};
		end else if (kind < 12) begin
			if (kind == 10 && model_written[c[6:0]]) begin
				prog[i] = {lw, 5'd0, a[4:0], 7'd0, c[6:0], 2'b00}; // Word stored by an earlier program
			end else begin
				prog[i] = {sw, 5'd0, a[4:0], 7'd0, c[6:0], 2'b00};
			end
		end else if (kind == 12) begin
			t = i + 1 + int'(c % 3);
			t = (t > prog_len) ? prog_len : t;
			is_target[t] = 1'b1; // Keeps jr slots unreachable by branches
			prog[i] = {c[8] ? bne : beq, a[4:0], b[4:0], 16'(t - i - 1)};
		end else if (kind == 13) begin
			t = i + 1 + int'(c % 4);
			t = (t > prog_len) ? prog_len : t;
			is_target[t] = 1'b1;
			prog[i] = {j, 26'(t)};
		end else if (kind == 14 && i + 2 < prog_len && !is_target[i + 2]) begin
			prog[i]     = {jal, 26'(i + 2)};         // Call into the jr two words on
			prog[i + 1] = {j, 26'(i + 3)};           // Return lands here, skips the jr
			prog[i + 2] = {6'h00, 5'd31, 15'd0, f_jr};
			i = i + 2;
		end else begin
			prog[i] = c[0] ? {6'h3f, c[25:0]} : {6'h00, c[25:6], 6'h3f}; // Undefined encoding
		end
		i = i + 1;
	end
endfunction

function automatic void reset_model();
	for (int k = 0; k < 32; k++) begin
		model_regs[k] = 32'd0;
	end
	model_pc = 32'd0;
endfunction

// One instruction of the ISA model, expected outputs for the current cycle
function automatic void ref_step();
	logic [31:0] inst;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] sext;
	logic [31:0] zext;
	logic [31:0] pc4;
	logic [31:0] next_pc;
	logic [31:0] res;
	logic [4:0]  dest;
	logic        nop;
	logic        load;
	logic        link;
	inst          = prog[model_pc[8:2]];
	a             = model_regs[inst[25:21]];
	b             = model_regs[inst[20:16]];
	sext          = {{16{inst[15]}}, inst[15:0]};
	zext          = {16'h0000, inst[15:0]};
	pc4           = model_pc + 32'd4;
	next_pc       = pc4;
	res           = 32'd0;
	dest          = inst[20:16]; // rt unless told otherwise
	nop           = 1'b0;
	load          = 1'b0;
	link          = 1'b0;
	exp_mem_write = 1'b0;
	case (inst[31:26])
		r_type: begin
			dest = inst[15:11];
			case (inst[5:0])
				f_add: res = a + b;
				f_sub: res = a - b;
				f_and: res = a & b;
				f_or:  res = a | b;
				f_slt: res = {31'd0, $signed(a) < $signed(b)};
				f_jr: begin
					next_pc = a;
					nop     = 1'b1;
				end
				default: nop = 1'b1;
			endcase
		end
		addi: res = a + sext;
		slti: res = {31'd0, $signed(a) < $signed(sext)};
		andi: res = a & zext;
		ori:  res = a | zext;
		lui:  res = {inst[15:0], 16'h0000};
		lw: begin
			res  = a + sext;
			load = 1'b1;
		end
		sw: begin
			res           = a + sext;
			exp_mem_write = 1'b1;
		end
		beq, bne: begin
			nop = 1'b1;
			if ((a == b) == (inst[31:26] == beq)) begin
				next_pc = pc4 + {sext[29:0], 2'b00}; // Word offset from the next instruction
			end
		end
		j, jal: begin
			next_pc = {pc4[31:28], inst[25:0], 2'b00};
			link    = (inst[31:26] == jal);
			dest    = 5'd31;
			nop     = ~link;
		end
		default: nop = 1'b1;
	endcase
	exp_pc        = model_pc;
	exp_alu       = res;
	exp_alu_valid = ~nop & ~link;
	exp_mem_addr  = res[8:2];
	exp_mem_wdata = b;
	if (exp_mem_write) begin
		model_mem[res[8:2]]     = b;
		model_written[res[8:2]] = 1'b1;
	end else if (!nop && dest != 5'd0) begin // r0 never changes
		model_regs[dest] = link ? pc4 : (load ? model_mem[res[8:2]] : res);
	end
	model_pc = next_pc;
endfunction

`endif

/* testbench/tb_mips_uniciclo.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_uniciclo #(
	parameter int num_programs = 20 // Random programs run back to back
);
	import mips_pkg::*;

	localparam int clk_period  = 8;
	localparam int prog_len    = 100;                 // Random words before the spin jump
	localparam int imem_words  = 2**imem_addr_width;
	localparam int run_cycles  = 150;
	localparam int load_cycles = imem_words + 3;      // Load plus strobe release and reset hold
	localparam int watchdog_ns = num_programs * (load_cycles + run_cycles) * clk_period
		+ 20 * clk_period;

	logic                       clk = 1'b0;
	logic                       reset;
	logic                       imem_load;
	logic [imem_addr_width-1:0] imem_addr;
	logic [data_width-1:0]      imem_data;
	logic [data_width-1:0]      pc;
	logic [data_width-1:0]      alu_result;
	logic                       mem_write;
	logic [dmem_addr_width-1:0] mem_addr;
	logic [data_width-1:0]      mem_wdata;
	logic                       running; // Checks enabled while a program executes

	logic [31:0]                prog [0:imem_words-1];
	logic                       is_target [0:imem_words-1];
	logic [31:0]                model_regs [0:31];
	logic [31:0]                model_mem [0:2**dmem_addr_width-1];
	logic                       model_written [0:2**dmem_addr_width-1];
	logic [31:0]                model_pc;
	logic [31:0]                rng_state;
	logic [31:0]                exp_pc;
	logic [31:0]                exp_alu;
	logic [31:0]                exp_mem_wdata;
	logic [dmem_addr_width-1:0] exp_mem_addr;
	logic                       exp_alu_valid;
	logic                       exp_mem_write;

	`include "mips_ref_model.svh"

	mips_uniciclo mips_uniciclo_i (
		.clk        (clk),
		.reset      (reset),
		.imem_load  (imem_load),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.pc         (pc),
		.alu_result (alu_result),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_value(input string field, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, field, actual, expected);
			$display("Finished with errors");
			$fatal(1, "Mismatch on %s", field);
		end
	endtask

	initial begin : stimulus
		reset     = 1'b1;
		imem_load = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		running   = 1'b0;
		rng_state = 32'h3546_91c9;
		@(negedge clk); // Model memory flags are cleared by now
		for (int p = 0; p < num_programs; p++) begin
			gen_program();
			prog[imem_words-1] = {sw, 5'd0, 5'd0, 16'd0}; // Unreachable store seen in reset
			for (int k = 0; k < imem_words; k++) begin
				@(negedge clk);
				imem_load = 1'b1;
				imem_addr = k[imem_addr_width-1:0];
				imem_data = prog[k];
			end
			@(negedge clk);
			imem_load = 1'b0;
			repeat (2) @(negedge clk);
			check_value("pc in reset", pc, 32'd0);
			check_value("mem_write in reset", {31'd0, mem_write}, 32'd0);
			reset   = 1'b0; // Word 0 runs in the coming cycle
			running = 1'b1;
			repeat (run_cycles) @(negedge clk);
			reset   = 1'b1;
			running = 1'b0;
		end
		$display("Finished with no errors");
		$finish;
	end

	initial begin : compare
		for (int k = 0; k < 2**dmem_addr_width; k++) begin
			model_written[k] = 1'b0; // Data memory starts unknown
		end
		forever begin
			@(negedge clk);
			#(clk_period / 4); // Outputs settled in the low phase
			if (!running) begin
				reset_model();
			end else begin
				ref_step();
				check_value("pc", pc, exp_pc);
				check_value("mem_write", {31'd0, mem_write}, {31'd0, exp_mem_write});
				if (exp_alu_valid) begin
					check_value("alu_result", alu_result, exp_alu);
				end
				if (exp_mem_write) begin
					check_value("mem_addr", {25'd0, mem_addr}, {25'd0, exp_mem_addr});
					check_value("mem_wdata", mem_wdata, exp_mem_wdata);
				end
			end
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Simulation timed out after %0d ns before all programs ran", watchdog_ns);
		$display("Finished with errors");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  logic [mips_pkg::data_width-1:0] operand_a,  // rs value
	input  logic [mips_pkg::data_width-1:0] read_data2, // rt value
	input  logic [mips_pkg::data_width-1:0] imm_ext,
	input  logic                            alu_src,
	input  mips_pkg::alu_op_t               alu_op,
	output logic [mips_pkg::data_width-1:0] result,
	output logic                            equal      // Branch compare of rs and rt
);
	import mips_pkg::*;

	logic [data_width-1:0] operand_b;
	logic                  less_than; // Signed compare of a and b

	assign operand_b = alu_src ? imm_ext : read_data2;
	assign less_than = $signed(operand_a) < $signed(operand_b);
	assign equal     = (operand_a == read_data2); // Always against the register, never the immediate

	always_comb begin
		case (alu_op)
			alu_add: result = operand_a + operand_b; // No overflow trap
			alu_sub: result = operand_a - operand_b;
			alu_and: result = operand_a & operand_b;
			alu_or:  result = operand_a | operand_b;
			alu_slt: result = {{(data_width-1){1'b0}}, less_than};
			alu_lui: result = {operand_b[15:0], 16'h0000}; // Low half cleared
			default: result = operand_a + operand_b;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
	input  logic [mips_pkg::data_width-1:0] instruction,
	output mips_pkg::pc_src_t               pc_src,
	output logic                            branch_ne,  // Inverts the branch condition
	output mips_pkg::reg_dst_t              reg_dst,
	output mips_pkg::wb_sel_t               wb_sel,
	output logic                            reg_write,
	output logic                            mem_write,
	output logic                            alu_src,    // Operand B from immediate
	output mips_pkg::alu_op_t               alu_op,
	output logic [mips_pkg::data_width-1:0] imm_ext
);
	import mips_pkg::*;

	opcode_t     opcode;
	funct_t      funct;
	logic        zero_ext; // Logical immediates are unsigned
	logic [15:0] imm;

	assign opcode = opcode_t'(instruction[31:26]);
	assign funct  = funct_t'(instruction[5:0]);
	assign imm    = instruction[15:0];

	assign zero_ext = (opcode == andi) || (opcode == ori);
	assign imm_ext  = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		pc_src    = pc_seq;  // Defaults give a no-op
		branch_ne = 1'b0;
		reg_dst   = dst_rt;
		wb_sel    = wb_alu;
		reg_write = 1'b0;
		mem_write = 1'b0;
		alu_src   = 1'b0;
		alu_op    = alu_add;
		case (opcode)
			r_type: begin
				reg_dst = dst_rd;
				case (funct)
					f_add: begin alu_op = alu_add; reg_write = 1'b1; end
					f_sub: begin alu_op = alu_sub; reg_write = 1'b1; end
					f_and: begin alu_op = alu_and; reg_write = 1'b1; end
					f_or:  begin alu_op = alu_or;  reg_write = 1'b1; end
					f_slt: begin alu_op = alu_slt; reg_write = 1'b1; end
					f_jr:  pc_src = pc_reg;             // No write-back
					default: ;                          // Unknown funct falls through as no-op
				endcase
			end
			addi: begin alu_src = 1'b1; alu_op = alu_add; reg_write = 1'b1; end
			slti: begin alu_src = 1'b1; alu_op = alu_slt; reg_write = 1'b1; end
			andi: begin alu_src = 1'b1; alu_op = alu_and; reg_write = 1'b1; end
			ori:  begin alu_src = 1'b1; alu_op = alu_or;  reg_write = 1'b1; end
			lui:  begin alu_src = 1'b1; alu_op = alu_lui; reg_write = 1'b1; end
			lw: begin
				alu_src   = 1'b1; // Base plus offset
				wb_sel    = wb_mem;
				reg_write = 1'b1;
			end
			sw: begin
				alu_src   = 1'b1;
				mem_write = 1'b1; // rt value goes to memory
			end
			beq: begin
				pc_src = pc_branch;
				alu_op = alu_sub;
			end
			bne: begin
				pc_src    = pc_branch;
				branch_ne = 1'b1;
				alu_op    = alu_sub;
			end
			j: pc_src = pc_jump;
			jal: begin
				pc_src    = pc_jump;
				reg_dst   = dst_ra;
				wb_sel    = wb_link; // pc plus 4 into r31
				reg_write = 1'b1;
			end
			default: ; // Unsupported opcode only advances the PC
		endcase
	end

endmodule

`default_nettype wire

/* verilog/program_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module program_counter (
	input  logic                          clk,
	input  logic                          reset,
	input  mips_pkg::pc_src_t             pc_src,         // Next address select from decoder
	input  logic                          branch_ne,      // Set for bne, clear for beq
	input  logic                          equal,          // Register compare from ALU
	input  logic [mips_pkg::data_width-1:0] imm_ext,      // Branch offset in words
	input  logic [mips_pkg::data_width-1:0] reg_target,   // rs value for jr
	input  logic [25:0]                   jump_index,     // Word index for j and jal
	output logic [mips_pkg::data_width-1:0] pc,
	output logic [mips_pkg::data_width-1:0] return_address
);
	import mips_pkg::*;

	logic [data_width-1:0] pc_plus4;      // Sequential address
	logic [data_width-1:0] branch_target; // Relative to the following instruction
	logic [data_width-1:0] jump_target;   // Region bits kept from pc plus 4
	logic                  branch_taken;
	logic [data_width-1:0] pc_next;

	assign pc_plus4       = pc + 32'd4;
	assign branch_target  = pc_plus4 + {imm_ext[data_width-3:0], 2'b00}; // Offset times 4
	assign jump_target    = {pc_plus4[data_width-1:28], jump_index, 2'b00};
	assign branch_taken   = (equal != branch_ne); // beq wants equal, bne wants not equal
	assign return_address = pc_plus4;             // Link value for jal

	always_comb begin
		case (pc_src)
			pc_branch: pc_next = branch_taken ? branch_target : pc_plus4;
			pc_jump:   pc_next = jump_target;
			pc_reg:    pc_next = reg_target;
			default:   pc_next = pc_plus4; // pc_seq and anything undecoded
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0; // Execution starts at word 0
		end else begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module register_bank (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [mips_pkg::reg_addr_width-1:0] rs,       // First source, instruction 25:21
	input  logic [mips_pkg::reg_addr_width-1:0] rt,       // Second source, instruction 20:16
	input  logic [mips_pkg::reg_addr_width-1:0] rd,       // Register format destination
	input  mips_pkg::reg_dst_t                reg_dst,
	input  logic                              reg_write,
	input  mips_pkg::wb_sel_t                 wb_sel,
	input  logic [mips_pkg::data_width-1:0]   alu_result,
	input  logic [mips_pkg::data_width-1:0]   mem_data,
	input  logic [mips_pkg::data_width-1:0]   return_address,
	output logic [mips_pkg::data_width-1:0]   read_data1,
	output logic [mips_pkg::data_width-1:0]   read_data2
);
	import mips_pkg::*;

	logic [data_width-1:0]     regs [0:2**reg_addr_width-1];
	logic [reg_addr_width-1:0] write_reg;  // Selected destination index
	logic [data_width-1:0]     write_data; // Selected write-back value

	always_comb begin
		case (reg_dst)
			dst_rd:  write_reg = rd;
			dst_ra:  write_reg = 5'd31; // jal links into ra
			default: write_reg = rt;
		endcase
	end

	always_comb begin
		case (wb_sel)
			wb_mem:  write_data = mem_data;
			wb_link: write_data = return_address;
			default: write_data = alu_result;
		endcase
	end

	assign read_data1 = regs[rs]; // Asynchronous reads
	assign read_data2 = regs[rt];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**reg_addr_width; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write && (write_reg != '0)) begin // r0 stays zero
			regs[write_reg] <= write_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/word_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module word_memory #(
	parameter int addr_width = 7 // Depth is 2**addr_width words
) (
	input  logic                            clk,
	input  logic                            write,      // Write strobe
	input  logic [addr_width-1:0]           address,    // Word address
	input  logic [mips_pkg::data_width-1:0] write_data,
	output logic [mips_pkg::data_width-1:0] read_data
);
	import mips_pkg::*;

	logic [data_width-1:0] mem [0:2**addr_width-1];

	assign read_data = mem[address]; // Read needs no clock

	always_ff @(posedge clk) begin
		if (write) begin
			mem[address] <= write_data;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+testbench
common/mips_pkg.sv
verilog/program_counter.sv
verilog/register_bank.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/word_memory.sv
mips_uniciclo/mips_uniciclo.sv
testbench/tb_mips_uniciclo.sv
